/* all.f */
design/soc_pkg.sv
design/bus_if.sv
design/dbus_decoder.sv
design/ram_arbiter.sv
design/gpio_regs.sv
design/ticker.sv
design/soc_bus_top.sv
dv/tb_soc_bus.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  - design/soc_pkg.sv
  - design/bus_if.sv
  - design/dbus_decoder.sv
  - design/ram_arbiter.sv
  - design/gpio_regs.sv
  - design/ticker.sv
  - design/soc_bus_top.sv
  - target: simulation
    files:
      - dv/tb_soc_bus.sv

/* dv/tb_soc_bus.sv */
`timescale 1ns/1ns

module tb_soc_bus;

    localparam int RAM_WORDS    = 1024;
    localparam int TICK_DIV     = 4;
    localparam int SEED         = 32'hdf5bd1bc;
    localparam int RESET_CYCLES = 10;

    localparam int NUM_INIT     = 64;
    localparam int NUM_RAND     = 150;
    localparam int NUM_CONC     = 150;
    localparam int NUM_GPIO     = 20;
    localparam int NUM_TICK_REG = 20;
    localparam int NUM_IRQ      = 4;
    localparam int NUM_UNMAP    = 20;
    localparam int TOTAL_XFERS  = NUM_INIT + 2 * NUM_RAND + 2 * NUM_CONC + 3 * NUM_GPIO +
                                  5 * NUM_TICK_REG + 5 * NUM_IRQ + 3 * NUM_UNMAP;
    localparam int WATCHDOG_CYCLES = TOTAL_XFERS * 20 + NUM_IRQ * TICK_DIV * 22 +
                                     RESET_CYCLES;

    // Address map and register offsets
    localparam logic [31:0] GPIO_BASE   = 32'h1000_0000;
    localparam logic [31:0] TICKER_BASE = 32'h1000_1000;
    localparam logic [31:0] UNMAPPED    = 32'hDEAD_BEEF;
    localparam logic [31:0] GPIO_OUT    = GPIO_BASE + 32'h0;
    localparam logic [31:0] GPIO_IN     = GPIO_BASE + 32'h4;
    localparam logic [31:0] TICK_COUNT  = TICKER_BASE + 32'h0;
    localparam logic [31:0] TICK_CMP    = TICKER_BASE + 32'h4;
    localparam logic [31:0] TICK_CTRL   = TICKER_BASE + 32'h8;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] ibus_address_i;
    logic        ibus_read_i;
    logic [31:0] ibus_rddata_o;
    logic        ibus_stall_o;
    logic [31:0] dbus_address_i;
    logic [3:0]  dbus_byteenable_i;
    logic [31:0] dbus_wrdata_i;
    logic        dbus_read_i;
    logic        dbus_write_i;
    logic [31:0] dbus_rddata_o;
    logic        dbus_stall_o;
    logic [31:0] gpio_i;
    logic [31:0] gpio_o;
    logic        timer_irq_o;

    // Reference model
    logic [31:0] ram_model [RAM_WORDS];
    logic [31:0] gpio_model;
    logic [31:0] cmp_model;
    logic [31:0] count_model;
    int          dbus_waits;

    soc_bus_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: a bus access never completed within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ########################################################################
    // Helpers and bus driver tasks
    // ########################################################################

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic int ram_index(input logic [31:0] addr);
        return (addr >> 2) % RAM_WORDS;
    endfunction

    // Random alias of the same word inside the 64 KB RAM window
    function automatic logic [31:0] ram_addr(input int idx);
        return 32'((idx + RAM_WORDS * $urandom_range(15, 0)) * 4) & 32'h0000_FFFF;
    endfunction

    function automatic logic [31:0] unmapped_addr();
        case ($urandom_range(2, 0))
            0:       return 32'h0001_0000 | ($urandom & 32'h0000_FFFF);
            1:       return 32'h1000_2000 | ($urandom & 32'h0000_0FFF);
            default: return 32'h8000_0000 | $urandom;
        endcase
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic dbus_access(input logic wr, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] wdata,
                               output logic [31:0] rdata, output int waits);
        @(posedge clk_i);
        dbus_address_i    <= addr;
        dbus_byteenable_i <= be;
        dbus_wrdata_i     <= wdata;
        dbus_read_i       <= !wr;
        dbus_write_i      <= wr;
        waits = 0;
        @(negedge clk_i);
        while (dbus_stall_o) begin
            waits++;
            @(negedge clk_i);
        end
        rdata = dbus_rddata_o;
        // Completing edge
        @(posedge clk_i);
        dbus_read_i  <= 1'b0;
        dbus_write_i <= 1'b0;
    endtask

    task automatic dbus_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [31:0] unused;
        dbus_access(1'b1, addr, be, data, unused, dbus_waits);
    endtask

    task automatic dbus_read(input logic [31:0] addr, output logic [31:0] rdata);
        dbus_access(1'b0, addr, 4'hF, 32'h0, rdata, dbus_waits);
    endtask

    task automatic ibus_fetch(input logic [31:0] addr, output logic [31:0] rdata);
        @(posedge clk_i);
        ibus_address_i <= addr;
        ibus_read_i    <= 1'b1;
        @(negedge clk_i);
        while (ibus_stall_o) @(negedge clk_i);
        rdata = ibus_rddata_o;
        @(posedge clk_i);
        ibus_read_i <= 1'b0;
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rd;
        logic [3:0]  be;
        int          n;
        int          limit;
        int          cycles;

        void'($urandom(SEED));
        rst_n_i           = 1'b0;
        ibus_address_i    = '0;
        ibus_read_i       = 1'b0;
        dbus_address_i    = '0;
        dbus_byteenable_i = '0;
        dbus_wrdata_i     = '0;
        dbus_read_i       = 1'b0;
        dbus_write_i      = 1'b0;
        gpio_i            = '0;
        gpio_model        = '0;
        cmp_model         = '0;
        count_model       = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_word(32'(ibus_stall_o), 32'h0, "ibus_stall_o after reset");
        check_word(32'(dbus_stall_o), 32'h0, "dbus_stall_o after reset");
        check_word(gpio_o, 32'h0, "gpio_o after reset");
        check_word(32'(timer_irq_o), 32'h0, "timer_irq_o after reset");

        // Fill the working set, then byte-enabled writes and reads
        for (int i = 0; i < NUM_INIT; i++) begin
            data = $urandom;
            addr = ram_addr(i);
            dbus_write(addr, 4'hF, data);
            ram_model[ram_index(addr)] = data;
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            addr = ram_addr($urandom_range(NUM_INIT - 1, 0));
            be   = $urandom;
            data = $urandom;
            dbus_write(addr, be, data);
            ram_model[ram_index(addr)] = merge_bytes(ram_model[ram_index(addr)], data, be);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            addr = ram_addr($urandom_range(NUM_INIT - 1, 0));
            dbus_read(addr, rd);
            check_word(rd, ram_model[ram_index(addr)], "data port RAM read");
        end

        // Both ports compete for the RAM
        fork
            begin
                logic [31:0] f_addr;
                logic [31:0] f_rd;
                for (int i = 0; i < NUM_CONC; i++) begin
                    f_addr = ram_addr($urandom_range(NUM_INIT - 1, 0));
                    ibus_fetch(f_addr, f_rd);
                    check_word(f_rd, ram_model[ram_index(f_addr)], "instruction fetch");
                end
            end
            begin
                for (int i = 0; i < NUM_CONC; i++) begin
                    addr = ram_addr($urandom_range(NUM_INIT - 1, 0));
                    if ($urandom_range(1, 0) == 1) begin
                        be   = $urandom;
                        data = $urandom;
                        dbus_write(addr, be, data);
                        ram_model[ram_index(addr)] =
                            merge_bytes(ram_model[ram_index(addr)], data, be);
                    end else begin
                        dbus_read(addr, rd);
                        check_word(rd, ram_model[ram_index(addr)], "concurrent data read");
                    end
                end
            end
        join

        // GPIO output and synchronized input
        for (int i = 0; i < NUM_GPIO; i++) begin
            be   = $urandom;
            data = $urandom;
            dbus_write(GPIO_OUT, be, data);
            gpio_model = merge_bytes(gpio_model, data, be);
            @(negedge clk_i);
            check_word(gpio_o, gpio_model, "gpio_o");
            dbus_read(GPIO_OUT, rd);
            check_word(rd, gpio_model, "GPIO output register");
            data = $urandom;
            @(posedge clk_i);
            gpio_i <= data;
            repeat (3) @(posedge clk_i);
            dbus_read(GPIO_IN, rd);
            check_word(rd, data, "GPIO input register");
        end

        // Ticker registers while disabled
        for (int i = 0; i < NUM_TICK_REG; i++) begin
            be   = $urandom;
            data = $urandom;
            dbus_write(TICK_COUNT, be, data);
            count_model = merge_bytes(count_model, data, be);
            be   = $urandom;
            data = $urandom;
            dbus_write(TICK_CMP, be, data);
            cmp_model = merge_bytes(cmp_model, data, be);
            dbus_read(TICK_COUNT, rd);
            check_word(rd, count_model, "ticker count");
            dbus_read(TICK_CMP, rd);
            check_word(rd, cmp_model, "ticker compare");
            repeat (8) @(posedge clk_i);
            dbus_read(TICK_COUNT, rd);
            check_word(rd, count_model, "idle ticker count");
        end

        // Ticker interrupt
        for (int i = 0; i < NUM_IRQ; i++) begin
            dbus_read(TICK_COUNT, rd);
            n = $urandom_range(20, 1);
            cmp_model = rd + 32'(n);
            dbus_write(TICK_CMP, 4'hF, cmp_model);
            dbus_write(TICK_CTRL, 4'h1, 32'h1);
            limit  = TICK_DIV * (n + 2);
            cycles = 0;
            @(negedge clk_i);
            while (!timer_irq_o && cycles < limit) begin
                cycles++;
                @(negedge clk_i);
            end
            check_word(32'(timer_irq_o), 32'h1, "timer_irq_o after compare match");
            dbus_read(TICK_CTRL, rd);
            check_word(rd, 32'h3, "ticker control with pending");
            // Disable and clear pending
            dbus_write(TICK_CTRL, 4'h1, 32'h2);
            @(negedge clk_i);
            check_word(32'(timer_irq_o), 32'h0, "timer_irq_o after clear");
        end

        // Unmapped accesses
        for (int i = 0; i < NUM_UNMAP; i++) begin
            dbus_read(unmapped_addr(), rd);
            check_word(rd, UNMAPPED, "unmapped read");
            check_word(32'(dbus_waits), 32'h0, "unmapped read stall cycles");
            // Low bits alias a word of the working set in RAM
            addr = (unmapped_addr() & ~32'h0000_0FFC) |
                   32'($urandom_range(NUM_INIT - 1, 0) * 4);
            dbus_write(addr, 4'hF, $urandom);
            check_word(32'(dbus_waits), 32'h0, "unmapped write stall cycles");
            @(negedge clk_i);
            check_word(gpio_o, gpio_model, "gpio_o after unmapped write");
            dbus_read(addr & 32'h0000_FFFF, rd);
            check_word(rd, ram_model[ram_index(addr)], "RAM word after unmapped write");
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* design/soc_bus_top.sv */
`timescale 1ns/1ns

module soc_bus_top #(
    parameter int RAM_WORDS = 1024,
    parameter int TICK_DIV  = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Instruction port, fetch only
    input  logic [soc_pkg::ADDR_W-1:0] ibus_address_i,
    input  logic                       ibus_read_i,
    output logic [soc_pkg::DATA_W-1:0] ibus_rddata_o,
    output logic                       ibus_stall_o,

    // Data port
    input  logic [soc_pkg::ADDR_W-1:0] dbus_address_i,
    input  logic [soc_pkg::BE_W-1:0]   dbus_byteenable_i,
    input  logic [soc_pkg::DATA_W-1:0] dbus_wrdata_i,
    input  logic                       dbus_read_i,
    input  logic                       dbus_write_i,
    output logic [soc_pkg::DATA_W-1:0] dbus_rddata_o,
    output logic                       dbus_stall_o,

    // Peripheral pins
    input  logic [soc_pkg::DATA_W-1:0] gpio_i,
    output logic [soc_pkg::DATA_W-1:0] gpio_o,
    output logic                       timer_irq_o
);

    bus_if ram_bus ();
    bus_if gpio_bus ();
    bus_if tick_bus ();

    // ########################################################################
    // Data bus routing
    // ########################################################################

    dbus_decoder u_dbus_decoder (
        .dbus_address_i    (dbus_address_i),
        .dbus_byteenable_i (dbus_byteenable_i),
        .dbus_wrdata_i     (dbus_wrdata_i),
        .dbus_read_i       (dbus_read_i),
        .dbus_write_i      (dbus_write_i),
        .dbus_rddata_o     (dbus_rddata_o),
        .dbus_stall_o      (dbus_stall_o),
        .ram_bus           (ram_bus.master),
        .gpio_bus          (gpio_bus.master),
        .tick_bus          (tick_bus.master)
    );

    // ########################################################################
    // Shared main RAM
    // ########################################################################

    ram_arbiter #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram_arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ibus_address_i (ibus_address_i),
        .ibus_read_i    (ibus_read_i),
        .ibus_rddata_o  (ibus_rddata_o),
        .ibus_stall_o   (ibus_stall_o),
        .dbus           (ram_bus.ram_slave)
    );

    // ########################################################################
    // Peripherals
    // ########################################################################

    gpio_regs u_gpio_regs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (gpio_bus.reg_slave),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o)
    );

    ticker #(
        .TICK_DIV (TICK_DIV)
    ) u_ticker (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (tick_bus.reg_slave),
        .irq_o   (timer_irq_o)
    );

endmodule

/* design/ticker.sv */
`timescale 1ns/1ns

module ticker #(
    parameter int TICK_DIV = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    bus_if.reg_slave bus,
    output logic     irq_o
);
    import soc_pkg::*;

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]     pre_q;
    logic [DATA_W-1:0]    count_q;
    logic [DATA_W-1:0]    cmp_q;
    logic                 en_q;
    logic                 pend_q;
    logic [REG_WIN_W-1:0] ofs;
    logic                 tick;
    logic                 hit;
    logic                 wr_count;
    logic                 wr_cmp;
    logic                 wr_ctrl;

    assign ofs      = bus.address[REG_WIN_W-1:0];
    assign wr_count = bus.write && ofs == TICK_COUNT_OFS;
    assign wr_cmp   = bus.write && ofs == TICK_CMP_OFS;
    assign wr_ctrl  = bus.write && ofs == TICK_CTRL_OFS && bus.byteenable[0];

    // One increment every TICK_DIV cycles
    assign tick = en_q && (pre_q == PRE_W'(TICK_DIV - 1));
    assign hit  = tick && !wr_count && (count_q + 1'b1 == cmp_q);

    // ########################################################################
    // Counter, compare and control
    // ########################################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pre_q   <= '0;
            count_q <= '0;
            cmp_q   <= '0;
            en_q    <= 1'b0;
            pend_q  <= 1'b0;
        end else begin
            if (!en_q || tick) begin
                pre_q <= '0;
            end else begin
                pre_q <= pre_q + 1'b1;
            end
            if (wr_count) begin
                count_q <= be_merge(count_q, bus.wrdata, bus.byteenable);
            end else if (tick) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_cmp) begin
                cmp_q <= be_merge(cmp_q, bus.wrdata, bus.byteenable);
            end
            if (wr_ctrl) begin
                en_q <= bus.wrdata[0];
            end
            // A new match wins over a clear in the same cycle
            if (hit) begin
                pend_q <= 1'b1;
            end else if (wr_ctrl && bus.wrdata[1]) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_comb begin
        bus.rddata = '0;
        if (bus.read) begin
            case (ofs)
                TICK_COUNT_OFS: bus.rddata = count_q;
                TICK_CMP_OFS:   bus.rddata = cmp_q;
                TICK_CTRL_OFS:  bus.rddata = {{(DATA_W-2){1'b0}}, pend_q, en_q};
                default:        bus.rddata = '0;
            endcase
        end
    end

    assign irq_o = pend_q;

endmodule

/* design/gpio_regs.sv */
`timescale 1ns/1ns

module gpio_regs (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    bus_if.reg_slave                   bus,
    input  logic [soc_pkg::DATA_W-1:0] gpio_i,
    output logic [soc_pkg::DATA_W-1:0] gpio_o
);
    import soc_pkg::*;

    logic [DATA_W-1:0]    out_q;
    logic [DATA_W-1:0]    in_meta_q;
    logic [DATA_W-1:0]    in_sync_q;
    logic [REG_WIN_W-1:0] ofs;

    assign ofs = bus.address[REG_WIN_W-1:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q     <= '0;
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            // Two flops before the pins become visible
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
            if (bus.write && ofs == GPIO_OUT_OFS) begin
                out_q <= be_merge(out_q, bus.wrdata, bus.byteenable);
            end
        end
    end

    always_comb begin
        bus.rddata = '0;
        if (bus.read) begin
            case (ofs)
                GPIO_OUT_OFS: bus.rddata = out_q;
                GPIO_IN_OFS:  bus.rddata = in_sync_q;
                default:      bus.rddata = '0;
            endcase
        end
    end

    assign gpio_o = out_q;

endmodule

/* design/ram_arbiter.sv */
`timescale 1ns/1ns

module ram_arbiter #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [soc_pkg::ADDR_W-1:0] ibus_address_i,
    input  logic                       ibus_read_i,
    output logic [soc_pkg::DATA_W-1:0] ibus_rddata_o,
    output logic                       ibus_stall_o,
    bus_if.ram_slave                   dbus
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [DATA_W-1:0] rd_q;

    arb_state_e state_q;
    arb_state_e state_d;

    logic [IDX_W-1:0] ibus_idx;
    logic [IDX_W-1:0] dbus_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_en;
    logic             rd_en;
    logic             dbus_done;

    // Word index, upper offset bits wrap
    assign ibus_idx = ibus_address_i[IDX_W+1:2];
    assign dbus_idx = dbus.address[IDX_W+1:2];

    // ########################################################################
    // Grant FSM
    // ########################################################################

    always_comb begin
        state_d = state_q;
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        rd_idx  = dbus_idx;
        case (state_q)
            ARB_IDLE: begin
                // Data port first
                if (dbus.write) begin
                    wr_en = 1'b1;
                end else if (dbus.read) begin
                    rd_en   = 1'b1;
                    state_d = ARB_DBUS_RD;
                end else if (ibus_read_i) begin
                    rd_en   = 1'b1;
                    rd_idx  = ibus_idx;
                    state_d = ARB_IBUS_RD;
                end
            end
            ARB_IBUS_RD: state_d = ARB_IDLE;
            ARB_DBUS_RD: state_d = ARB_IDLE;
            default:     state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ########################################################################
    // Array and registered read word
    // ########################################################################

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (dbus.byteenable[b]) begin
                    mem[dbus_idx][8*b +: 8] <= dbus.wrdata[8*b +: 8];
                end
            end
        end
        if (rd_en) begin
            rd_q <= mem[rd_idx];
        end
    end

    assign dbus_done = (state_q == ARB_IDLE && dbus.write) ||
                       (state_q == ARB_DBUS_RD && dbus.read);

    assign dbus.stall   = (dbus.read || dbus.write) && !dbus_done;
    assign dbus.rddata  = rd_q;
    assign ibus_stall_o = ibus_read_i && (state_q != ARB_IBUS_RD);
    assign ibus_rddata_o = rd_q;

endmodule

/* design/dbus_decoder.sv */
`timescale 1ns/1ns

module dbus_decoder (
    input  logic [soc_pkg::ADDR_W-1:0] dbus_address_i,
    input  logic [soc_pkg::BE_W-1:0]   dbus_byteenable_i,
    input  logic [soc_pkg::DATA_W-1:0] dbus_wrdata_i,
    input  logic                       dbus_read_i,
    input  logic                       dbus_write_i,
    output logic [soc_pkg::DATA_W-1:0] dbus_rddata_o,
    output logic                       dbus_stall_o,
    bus_if.master                      ram_bus,
    bus_if.master                      gpio_bus,
    bus_if.master                      tick_bus
);
    import soc_pkg::*;

    bus_target_e tgt;
    logic        hit_ram;
    logic        hit_gpio;
    logic        hit_ticker;

    // ########################################################################
    // Address decode
    // ########################################################################

    assign hit_ram    = dbus_address_i[ADDR_W-1:RAM_WIN_W] ==
                        RAM_BASE[ADDR_W-1:RAM_WIN_W];
    assign hit_gpio   = dbus_address_i[ADDR_W-1:REG_WIN_W] ==
                        GPIO_BASE[ADDR_W-1:REG_WIN_W];
    assign hit_ticker = dbus_address_i[ADDR_W-1:REG_WIN_W] ==
                        TICKER_BASE[ADDR_W-1:REG_WIN_W];

    always_comb begin
        if (hit_ram) begin
            tgt = TGT_RAM;
        end else if (hit_gpio) begin
            tgt = TGT_GPIO;
        end else if (hit_ticker) begin
            tgt = TGT_TICKER;
        end else begin
            tgt = TGT_NONE;
        end
    end

    // ########################################################################
    // Request steering
    // ########################################################################

    // Payload goes everywhere, only the selected target sees a strobe
    assign ram_bus.address    = ADDR_W'(dbus_address_i[RAM_WIN_W-1:0]);
    assign ram_bus.byteenable = dbus_byteenable_i;
    assign ram_bus.wrdata     = dbus_wrdata_i;
    assign ram_bus.read       = dbus_read_i && (tgt == TGT_RAM);
    assign ram_bus.write      = dbus_write_i && (tgt == TGT_RAM);

    assign gpio_bus.address    = ADDR_W'(dbus_address_i[REG_WIN_W-1:0]);
    assign gpio_bus.byteenable = dbus_byteenable_i;
    assign gpio_bus.wrdata     = dbus_wrdata_i;
    assign gpio_bus.read       = dbus_read_i && (tgt == TGT_GPIO);
    assign gpio_bus.write      = dbus_write_i && (tgt == TGT_GPIO);

    assign tick_bus.address    = ADDR_W'(dbus_address_i[REG_WIN_W-1:0]);
    assign tick_bus.byteenable = dbus_byteenable_i;
    assign tick_bus.wrdata     = dbus_wrdata_i;
    assign tick_bus.read       = dbus_read_i && (tgt == TGT_TICKER);
    assign tick_bus.write      = dbus_write_i && (tgt == TGT_TICKER);

    // ########################################################################
    // Response return
    // ########################################################################

    always_comb begin
        case (tgt)
            TGT_RAM:    dbus_rddata_o = ram_bus.rddata;
            TGT_GPIO:   dbus_rddata_o = gpio_bus.rddata;
            TGT_TICKER: dbus_rddata_o = tick_bus.rddata;
            default:    dbus_rddata_o = UNMAPPED_DATA;
        endcase
    end

    // Only the RAM can hold off the CPU
    assign dbus_stall_o = (tgt == TGT_RAM) ? ram_bus.stall : 1'b0;

endmodule

/* design/bus_if.sv */
`timescale 1ns/1ns

interface bus_if;
    import soc_pkg::*;

    logic [ADDR_W-1:0] address;
    logic [BE_W-1:0]   byteenable;
    logic [DATA_W-1:0] wrdata;
    logic              read;
    logic              write;
    logic [DATA_W-1:0] rddata;
    logic              stall;

    modport master (
        output address, byteenable, wrdata, read, write,
        input  rddata, stall
    );

    // RAM side can hold off the master
    modport ram_slave (
        input  address, byteenable, wrdata, read, write,
        output rddata, stall
    );

    // Register blocks answer in the request cycle
    modport reg_slave (
        input  address, byteenable, wrdata, read, write,
        output rddata
    );

endinterface

/* design/soc_pkg.sv */
package soc_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Window sizes as address bit counts
    localparam int RAM_WIN_W = 16;
    localparam int REG_WIN_W = 12;

    // Address map
    localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] GPIO_BASE   = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] TICKER_BASE = 32'h1000_1000;

    localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Register byte offsets inside a window
    localparam logic [REG_WIN_W-1:0] GPIO_OUT_OFS   = 12'h000;
    localparam logic [REG_WIN_W-1:0] GPIO_IN_OFS    = 12'h004;
    localparam logic [REG_WIN_W-1:0] TICK_COUNT_OFS = 12'h000;
    localparam logic [REG_WIN_W-1:0] TICK_CMP_OFS   = 12'h004;
    localparam logic [REG_WIN_W-1:0] TICK_CTRL_OFS  = 12'h008;

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_GPIO,
        TGT_TICKER,
        TGT_NONE
    } bus_target_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_IBUS_RD,
        ARB_DBUS_RD
    } arb_state_e;

    // Replace the enabled bytes of a register word
    function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_word,
                                                   input logic [DATA_W-1:0] new_word,
                                                   input logic [BE_W-1:0]   be);
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage
